//--- include/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// bus widths, single 32-bit beat everywhere
`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_STRB_W 4

// CLINT window in the system address map
`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000

// CLINT register offsets, low 16 address bits
`define CLINT_MTIMECMP_LO 16'h4000
`define CLINT_MTIMECMP_HI 16'h4004
`define CLINT_MTIME_LO    16'hBFF8
`define CLINT_MTIME_HI    16'hBFFC

`endif

//--- verilog/mem_pkg.sv
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

    // AXI style response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // one request beat, fetch or data
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic                   write;
        logic [`MEM_DATA_W-1:0] wdata;
        logic [`MEM_STRB_W-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] rdata;
        resp_e                  resp;
    } mem_rsp_t;

    // AXI channels, IDs and burst fields left out
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] data;
        logic [`MEM_STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [`MEM_DATA_W-1:0] data;
        resp_e                  resp;
    } axi_r_t;

    typedef struct packed {
        resp_e resp;
    } axi_b_t;

endpackage

`default_nettype wire

//--- verilog/mem_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter (
    input  logic               clock,
    input  logic               reset,

    input  logic               fetch_req_valid,
    input  mem_pkg::mem_req_t  fetch_req,
    output logic               fetch_req_ready,
    output logic               fetch_rsp_valid,
    output mem_pkg::mem_rsp_t  fetch_rsp,
    input  logic               fetch_rsp_ready,

    input  logic               data_req_valid,
    input  mem_pkg::mem_req_t  data_req,
    output logic               data_req_ready,
    output logic               data_rsp_valid,
    output mem_pkg::mem_rsp_t  data_rsp,
    input  logic               data_rsp_ready,

    output logic               out_req_valid,
    output mem_pkg::mem_req_t  out_req,
    input  logic               out_req_ready,
    input  logic               out_rsp_valid,
    input  mem_pkg::mem_rsp_t  out_rsp,
    output logic               out_rsp_ready
);

    // owner and last_data: 1 means the data port
    logic busy;
    logic owner;
    logic last_data;
    logic grant_data;
    logic req_fire;
    logic rsp_fire;

    // round robin only matters when both ask at once
    always_comb begin
        if (fetch_req_valid && data_req_valid) begin
            grant_data = !last_data;
        end else begin
            grant_data = data_req_valid;
        end
    end

    assign out_req_valid   = !busy && (fetch_req_valid || data_req_valid);
    assign out_req         = grant_data ? data_req : fetch_req;
    assign fetch_req_ready = !busy && !grant_data && out_req_ready;
    assign data_req_ready  = !busy && grant_data && out_req_ready;

    assign req_fire = out_req_valid && out_req_ready;

    // response goes back only to the port that owns the transaction
    assign fetch_rsp_valid = busy && !owner && out_rsp_valid;
    assign data_rsp_valid  = busy && owner && out_rsp_valid;
    assign fetch_rsp       = out_rsp;
    assign data_rsp        = out_rsp;
    assign out_rsp_ready   = busy && (owner ? data_rsp_ready : fetch_rsp_ready);

    assign rsp_fire = out_rsp_valid && out_rsp_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            owner     <= 1'b0;
            last_data <= 1'b0;
        end else begin
            if (req_fire) begin
                busy      <= 1'b1;
                owner     <= grant_data;
                last_data <= grant_data;
            end else if (rsp_fire) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_addr_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_addr_router (
    input  logic               clock,
    input  logic               reset,

    input  logic               in_req_valid,
    input  mem_pkg::mem_req_t  in_req,
    output logic               in_req_ready,
    output logic               in_rsp_valid,
    output mem_pkg::mem_rsp_t  in_rsp,
    input  logic               in_rsp_ready,

    output logic               clint_req_valid,
    output mem_pkg::mem_req_t  clint_req,
    input  logic               clint_req_ready,
    input  logic               clint_rsp_valid,
    input  mem_pkg::mem_rsp_t  clint_rsp,
    output logic               clint_rsp_ready,

    output logic               soc_req_valid,
    output mem_pkg::mem_req_t  soc_req,
    input  logic               soc_req_ready,
    input  logic               soc_rsp_valid,
    input  mem_pkg::mem_rsp_t  soc_rsp,
    output logic               soc_rsp_ready
);

    logic hit_clint;
    logic target_clint;
    logic req_fire;

    // CLINT window decode, everything else goes out to the SoC
    assign hit_clint = (in_req.addr >= `CLINT_BASE) &&
                       (in_req.addr <  (`CLINT_BASE + `CLINT_SIZE));

    assign clint_req_valid = in_req_valid && hit_clint;
    assign soc_req_valid   = in_req_valid && !hit_clint;
    assign clint_req       = in_req;
    assign soc_req         = in_req;
    assign in_req_ready    = hit_clint ? clint_req_ready : soc_req_ready;

    assign req_fire = in_req_valid && in_req_ready;

    // remember where the outstanding request went
    always_ff @(posedge clock) begin
        if (reset) begin
            target_clint <= 1'b0;
        end else if (req_fire) begin
            target_clint <= hit_clint;
        end
    end

    assign in_rsp_valid    = target_clint ? clint_rsp_valid : soc_rsp_valid;
    assign in_rsp          = target_clint ? clint_rsp : soc_rsp;
    assign clint_rsp_ready = target_clint && in_rsp_ready;
    assign soc_rsp_ready   = !target_clint && in_rsp_ready;

endmodule

`default_nettype wire

//--- verilog/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module clint_timer (
    input  logic               clock,
    input  logic               reset,

    input  logic               req_valid,
    input  mem_pkg::mem_req_t  req,
    output logic               req_ready,
    output logic               rsp_valid,
    output mem_pkg::mem_rsp_t  rsp,
    input  logic               rsp_ready
);

    logic [63:0]            mtime;
    logic [63:0]            mtimecmp;
    logic [`MEM_DATA_W-1:0] rdata_q;
    logic [`MEM_DATA_W-1:0] read_word;
    logic [15:0]            offset;
    logic                   accept;
    logic                   wr;

    // byte lane merge under the write strobe
    function automatic logic [`MEM_DATA_W-1:0] merge_word(
        input logic [`MEM_DATA_W-1:0] old_word,
        input logic [`MEM_DATA_W-1:0] new_word,
        input logic [`MEM_STRB_W-1:0] strb
    );
        logic [`MEM_DATA_W-1:0] res;
        res = old_word;
        for (int i = 0; i < `MEM_STRB_W; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign offset    = req.addr[15:0];
    assign req_ready = !rsp_valid;
    assign accept    = req_valid && req_ready;
    assign wr        = accept && req.write;

    always_comb begin
        case (offset)
            `CLINT_MTIMECMP_LO: read_word = mtimecmp[31:0];
            `CLINT_MTIMECMP_HI: read_word = mtimecmp[63:32];
            `CLINT_MTIME_LO:    read_word = mtime[31:0];
            `CLINT_MTIME_HI:    read_word = mtime[63:32];
            default:            read_word = '0;
        endcase
    end

    // a write to mtime takes the place of the increment for that cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            mtime <= '0;
        end else if (wr && offset == `CLINT_MTIME_LO) begin
            mtime[31:0] <= merge_word(mtime[31:0], req.wdata, req.wstrb);
        end else if (wr && offset == `CLINT_MTIME_HI) begin
            mtime[63:32] <= merge_word(mtime[63:32], req.wdata, req.wstrb);
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mtimecmp <= '1;
        end else if (wr && offset == `CLINT_MTIMECMP_LO) begin
            mtimecmp[31:0] <= merge_word(mtimecmp[31:0], req.wdata, req.wstrb);
        end else if (wr && offset == `CLINT_MTIMECMP_HI) begin
            mtimecmp[63:32] <= merge_word(mtimecmp[63:32], req.wdata, req.wstrb);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // sample read data at accept so it holds while mtime keeps counting
    always_ff @(posedge clock) begin
        if (accept) begin
            rdata_q <= req.write ? '0 : read_word;
        end
    end

    assign rsp = mem_pkg::mem_rsp_t'{rdata: rdata_q, resp: mem_pkg::RESP_OKAY};

endmodule

`default_nettype wire

//--- verilog/soc_axi_master.sv
`timescale 1ns/1ps
`default_nettype none

module soc_axi_master (
    input  logic               clock,
    input  logic               reset,

    input  logic               req_valid,
    input  mem_pkg::mem_req_t  req,
    output logic               req_ready,
    output logic               rsp_valid,
    output mem_pkg::mem_rsp_t  rsp,
    input  logic               rsp_ready,

    output logic               aw_valid,
    output mem_pkg::axi_aw_t   aw,
    input  logic               aw_ready,
    output logic               w_valid,
    output mem_pkg::axi_w_t    w,
    input  logic               w_ready,
    input  logic               b_valid,
    input  mem_pkg::axi_b_t    b,
    output logic               b_ready,
    output logic               ar_valid,
    output mem_pkg::axi_ar_t   ar,
    input  logic               ar_ready,
    input  logic               r_valid,
    input  mem_pkg::axi_r_t    r,
    output logic               r_ready
);

    mem_pkg::mem_req_t req_q;
    logic              busy;
    logic              aw_done;
    logic              w_done;
    logic              ar_done;
    logic              wr_active;
    logic              rd_active;
    logic              b_wait;
    logic              r_wait;
    logic              req_fire;

    // one transaction at a time, a write holds us until its B
    assign req_ready = !busy;
    assign req_fire  = req_valid && req_ready;

    assign wr_active = busy && req_q.write;
    assign rd_active = busy && !req_q.write;
    assign b_wait    = wr_active && aw_done && w_done;
    assign r_wait    = rd_active && ar_done;

    // AW and W rise together, each drops on its own handshake
    assign aw_valid = wr_active && !aw_done;
    assign w_valid  = wr_active && !w_done;
    assign ar_valid = rd_active && !ar_done;
    assign aw       = mem_pkg::axi_aw_t'{addr: req_q.addr};
    assign w        = mem_pkg::axi_w_t'{data: req_q.wdata, strb: req_q.wstrb};
    assign ar       = mem_pkg::axi_ar_t'{addr: req_q.addr};

    // B or R passes straight through to the response channel
    assign b_ready   = b_wait && rsp_ready;
    assign r_ready   = r_wait && rsp_ready;
    assign rsp_valid = (b_wait && b_valid) || (r_wait && r_valid);
    assign rsp.rdata = req_q.write ? '0 : r.data;
    assign rsp.resp  = req_q.write ? b.resp : r.resp;

    always_ff @(posedge clock) begin
        if (req_fire) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy    <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
        end else if (req_fire) begin
            busy    <= 1'b1;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_done <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_done <= 1'b1;
            end
            if (ar_valid && ar_ready) begin
                ar_done <= 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  logic               clock,
    input  logic               reset,

    input  logic               fetch_req_valid,
    input  mem_pkg::mem_req_t  fetch_req,
    output logic               fetch_req_ready,
    output logic               fetch_rsp_valid,
    output mem_pkg::mem_rsp_t  fetch_rsp,
    input  logic               fetch_rsp_ready,

    input  logic               data_req_valid,
    input  mem_pkg::mem_req_t  data_req,
    output logic               data_req_ready,
    output logic               data_rsp_valid,
    output mem_pkg::mem_rsp_t  data_rsp,
    input  logic               data_rsp_ready,

    output logic               aw_valid,
    output mem_pkg::axi_aw_t   aw,
    input  logic               aw_ready,
    output logic               w_valid,
    output mem_pkg::axi_w_t    w,
    input  logic               w_ready,
    input  logic               b_valid,
    input  mem_pkg::axi_b_t    b,
    output logic               b_ready,
    output logic               ar_valid,
    output mem_pkg::axi_ar_t   ar,
    input  logic               ar_ready,
    input  logic               r_valid,
    input  mem_pkg::axi_r_t    r,
    output logic               r_ready
);

    // arbiter to router
    logic              mem_req_valid;
    mem_pkg::mem_req_t mem_req;
    logic              mem_req_ready;
    logic              mem_rsp_valid;
    mem_pkg::mem_rsp_t mem_rsp;
    logic              mem_rsp_ready;

    // router to CLINT
    logic              clint_req_valid;
    mem_pkg::mem_req_t clint_req;
    logic              clint_req_ready;
    logic              clint_rsp_valid;
    mem_pkg::mem_rsp_t clint_rsp;
    logic              clint_rsp_ready;

    // router to SoC AXI master
    logic              soc_req_valid;
    mem_pkg::mem_req_t soc_req;
    logic              soc_req_ready;
    logic              soc_rsp_valid;
    mem_pkg::mem_rsp_t soc_rsp;
    logic              soc_rsp_ready;

    mem_port_arbiter arbiter_inst (
        .clock           (clock),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_req_ready  (data_req_ready),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp),
        .data_rsp_ready  (data_rsp_ready),
        .out_req_valid   (mem_req_valid),
        .out_req         (mem_req),
        .out_req_ready   (mem_req_ready),
        .out_rsp_valid   (mem_rsp_valid),
        .out_rsp         (mem_rsp),
        .out_rsp_ready   (mem_rsp_ready)
    );

    mem_addr_router router_inst (
        .clock           (clock),
        .reset           (reset),
        .in_req_valid    (mem_req_valid),
        .in_req          (mem_req),
        .in_req_ready    (mem_req_ready),
        .in_rsp_valid    (mem_rsp_valid),
        .in_rsp          (mem_rsp),
        .in_rsp_ready    (mem_rsp_ready),
        .clint_req_valid (clint_req_valid),
        .clint_req       (clint_req),
        .clint_req_ready (clint_req_ready),
        .clint_rsp_valid (clint_rsp_valid),
        .clint_rsp       (clint_rsp),
        .clint_rsp_ready (clint_rsp_ready),
        .soc_req_valid   (soc_req_valid),
        .soc_req         (soc_req),
        .soc_req_ready   (soc_req_ready),
        .soc_rsp_valid   (soc_rsp_valid),
        .soc_rsp         (soc_rsp),
        .soc_rsp_ready   (soc_rsp_ready)
    );

    clint_timer clint_inst (
        .clock     (clock),
        .reset     (reset),
        .req_valid (clint_req_valid),
        .req       (clint_req),
        .req_ready (clint_req_ready),
        .rsp_valid (clint_rsp_valid),
        .rsp       (clint_rsp),
        .rsp_ready (clint_rsp_ready)
    );

    soc_axi_master soc_master_inst (
        .clock     (clock),
        .reset     (reset),
        .req_valid (soc_req_valid),
        .req       (soc_req),
        .req_ready (soc_req_ready),
        .rsp_valid (soc_rsp_valid),
        .rsp       (soc_rsp),
        .rsp_ready (soc_rsp_ready),
        .aw_valid  (aw_valid),
        .aw        (aw),
        .aw_ready  (aw_ready),
        .w_valid   (w_valid),
        .w         (w),
        .w_ready   (w_ready),
        .b_valid   (b_valid),
        .b         (b),
        .b_ready   (b_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  logic              clock,
    input  logic              reset,
    input  logic              aw_valid,
    input  mem_pkg::axi_aw_t  aw,
    output logic              aw_ready,
    input  logic              w_valid,
    input  mem_pkg::axi_w_t   w,
    output logic              w_ready,
    output logic              b_valid,
    output mem_pkg::axi_b_t   b,
    input  logic              b_ready,
    input  logic              ar_valid,
    input  mem_pkg::axi_ar_t  ar,
    output logic              ar_ready,
    output logic              r_valid,
    output mem_pkg::axi_r_t   r,
    input  logic              r_ready,
    output int                violations
);

    logic [31:0] mem [0:63];
    logic [31:0] rng = 32'd66116;
    logic        aw_rdy_q = 1'b0;
    logic        w_rdy_q = 1'b0;
    logic        ar_rdy_q = 1'b0;
    logic        b_q = 1'b0;
    logic        r_q = 1'b0;
    logic [31:0] r_data = '0;
    logic        have_aw = 1'b0;
    logic        have_w = 1'b0;
    logic        rd_have = 1'b0;
    logic        write_open = 1'b0;
    logic        aw_prev = 1'b0;
    logic        w_prev = 1'b0;
    logic [31:0] wr_addr = '0;
    logic [31:0] wr_data = '0;
    logic [3:0]  wr_strb = '0;
    logic [31:0] rd_addr = '0;
    int          viol_count = 0;

    assign aw_ready   = aw_rdy_q;
    assign w_ready    = w_rdy_q;
    assign ar_ready   = ar_rdy_q;
    assign b_valid    = b_q;
    assign r_valid    = r_q;
    assign b          = mem_pkg::axi_b_t'{resp: mem_pkg::RESP_OKAY};
    assign r          = mem_pkg::axi_r_t'{data: r_data, resp: mem_pkg::RESP_OKAY};
    assign violations = viol_count;

    // pattern built from the whole word address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ (a << 13) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always @(posedge clock) begin
        rng = lcg_step(rng);
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                mem[i] <= fill_word(32'h8000_0000 + 32'(i * 4));
            end
            aw_rdy_q   <= 1'b0;
            w_rdy_q    <= 1'b0;
            ar_rdy_q   <= 1'b0;
            b_q        <= 1'b0;
            r_q        <= 1'b0;
            have_aw    <= 1'b0;
            have_w     <= 1'b0;
            rd_have    <= 1'b0;
            write_open <= 1'b0;
            aw_prev    <= 1'b0;
            w_prev     <= 1'b0;
        end else begin
            // AW and W must rise in the same cycle
            if ((aw_valid && !aw_prev) != (w_valid && !w_prev)) begin
                viol_count++;
                $display("AXI protocol problem at %0t: aw_valid and w_valid did not rise together",
                         $time);
            end
            if (aw_valid && !aw_prev && write_open) begin
                viol_count++;
                $display("AXI protocol problem at %0t: new AW before the previous B", $time);
            end
            if (b_q && b_ready) begin
                b_q        <= 1'b0;
                write_open <= 1'b0;
            end
            if (aw_valid && !aw_prev) begin
                write_open <= 1'b1;
            end
            aw_prev <= aw_valid;
            w_prev  <= w_valid;

            if (aw_valid && aw_rdy_q) begin
                have_aw <= 1'b1;
                wr_addr <= aw.addr;
            end
            if (w_valid && w_rdy_q) begin
                have_w  <= 1'b1;
                wr_data <= w.data;
                wr_strb <= w.strb;
            end
            aw_rdy_q <= !have_aw && !(aw_valid && aw_rdy_q) && rng[17];
            w_rdy_q  <= !have_w && !(w_valid && w_rdy_q) && rng[18];

            // random delay before B
            if (have_aw && have_w && !b_q && rng[19]) begin
                for (int i = 0; i < 4; i++) begin
                    if (wr_strb[i]) begin
                        mem[wr_addr[7:2]][8*i +: 8] <= wr_data[8*i +: 8];
                    end
                end
                b_q     <= 1'b1;
                have_aw <= 1'b0;
                have_w  <= 1'b0;
            end

            if (ar_valid && ar_rdy_q) begin
                rd_have <= 1'b1;
                rd_addr <= ar.addr;
            end
            ar_rdy_q <= !rd_have && !(ar_valid && ar_rdy_q) && rng[20];
            if (rd_have && !r_q && rng[21]) begin
                r_q     <= 1'b1;
                r_data  <= mem[rd_addr[7:2]];
                rd_have <= 1'b0;
            end
            if (r_q && r_ready) begin
                r_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsystem_tb;

    localparam int num_trans = 200;
    localparam logic [31:0] soc_base = 32'h8000_0000;

    logic clock;
    logic reset;

    logic              fetch_req_valid = 1'b0;
    mem_pkg::mem_req_t fetch_req = '0;
    logic              fetch_req_ready;
    logic              fetch_rsp_valid;
    mem_pkg::mem_rsp_t fetch_rsp;
    logic              fetch_rsp_ready = 1'b0;
    logic              data_req_valid = 1'b0;
    mem_pkg::mem_req_t data_req = '0;
    logic              data_req_ready;
    logic              data_rsp_valid;
    mem_pkg::mem_rsp_t data_rsp;
    logic              data_rsp_ready = 1'b0;

    logic aw_valid;
    logic aw_ready;
    logic w_valid;
    logic w_ready;
    logic b_valid;
    logic b_ready;
    logic ar_valid;
    logic ar_ready;
    logic r_valid;
    logic r_ready;
    mem_pkg::axi_aw_t aw;
    mem_pkg::axi_w_t  w;
    mem_pkg::axi_b_t  b;
    mem_pkg::axi_ar_t ar;
    mem_pkg::axi_r_t  r;
    int axi_violations;

    // reference model
    logic [7:0]  soc_bytes [0:255];
    logic [63:0] mtimecmp;
    logic [31:0] mtime_hi;

    logic [31:0]       rng_state = 32'd66116;
    logic [31:0]       fetch_q [$];
    logic [31:0]       data_q [$];
    logic              held_valid [2];
    mem_pkg::mem_rsp_t held_rsp [2];
    int                done_cnt [2];
    int                errors = 0;
    int                fetch_issued = 0;
    int                data_issued = 0;
    int                fetch_gap = 0;
    int                data_gap = 0;
    logic [31:0]       exp_word;
    logic [31:0]       fill_tmp;
    mem_pkg::mem_req_t new_req;

    tb_clock_gen clock_gen_inst (.clock(clock), .reset(reset));

    mem_subsystem mem_subsystem_inst (.*);

    axi_mem_model axi_mem_inst (.*, .violations(axi_violations));

    function automatic logic [31:0] rand_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ (a << 13) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] strobe_merge(input logic [31:0] old_w,
                                                 input logic [31:0] new_w,
                                                 input logic [3:0] s);
        logic [31:0] mask;
        mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic make_request(input logic is_data, output mem_pkg::mem_req_t q);
        logic [31:0] rv;
        rv = rand_next();
        q = '0;
        q.addr = soc_base + {24'd0, rv[21:16], 2'b00};
        if (is_data) begin
            q.write = rv[22];
            q.wdata = rand_next();
            q.wstrb = rv[26:23];
            case (rv[29:27])
                3'd5: q.addr = `CLINT_BASE + {16'd0, rv[30] ? `CLINT_MTIMECMP_HI
                                                            : `CLINT_MTIMECMP_LO};
                3'd6: q.addr = `CLINT_BASE + {16'd0, `CLINT_MTIME_HI};
                // unmapped CLINT offset
                3'd7: q.addr = `CLINT_BASE + 32'h0000_0100;
                default: ;
            endcase
        end
    endtask

    // update the model at acceptance and return the word the response must carry
    task automatic accept_request(input mem_pkg::mem_req_t q, output logic [31:0] exp);
        logic [7:0] base;
        exp = '0;
        if (q.addr >= `CLINT_BASE && q.addr < `CLINT_BASE + `CLINT_SIZE) begin
            case (q.addr[15:0])
                `CLINT_MTIMECMP_LO: begin
                    if (q.write) mtimecmp[31:0] = strobe_merge(mtimecmp[31:0], q.wdata, q.wstrb);
                    else exp = mtimecmp[31:0];
                end
                `CLINT_MTIMECMP_HI: begin
                    if (q.write) mtimecmp[63:32] = strobe_merge(mtimecmp[63:32], q.wdata, q.wstrb);
                    else exp = mtimecmp[63:32];
                end
                `CLINT_MTIME_HI: begin
                    if (q.write) mtime_hi = strobe_merge(mtime_hi, q.wdata, q.wstrb);
                    else exp = mtime_hi;
                end
                default: ;
            endcase
        end else begin
            base = {q.addr[7:2], 2'b00};
            for (int i = 0; i < 4; i++) begin
                if (q.write && q.wstrb[i]) soc_bytes[int'(base) + i] = q.wdata[8*i +: 8];
                if (!q.write) exp[8*i +: 8] = soc_bytes[int'(base) + i];
            end
        end
    endtask

    task automatic watch_response(input int port, input logic valid, input logic ready,
                                  input mem_pkg::mem_rsp_t rsp);
        logic [31:0] exp;
        if (held_valid[port] && !valid) begin
            errors++;
            $display("port %0d dropped its response at %0t before it was taken", port, $time);
        end
        if (held_valid[port] && valid) begin
            check_value({30'd0, rsp}, {30'd0, held_rsp[port]}, "held response payload");
        end
        held_valid[port] = valid && !ready;
        held_rsp[port]   = rsp;
        if (valid && ready) begin
            if ((port == 0 && fetch_q.size() == 0) || (port == 1 && data_q.size() == 0)) begin
                errors++;
                $display("port %0d got a response at %0t with no request open", port, $time);
            end else begin
                if (port == 0) begin
                    exp = fetch_q.pop_front();
                end else begin
                    exp = data_q.pop_front();
                end
                check_value({32'd0, rsp.rdata}, {32'd0, exp}, "response data");
                check_value({62'd0, rsp.resp}, {62'd0, mem_pkg::RESP_OKAY}, "response code");
                done_cnt[port]++;
            end
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < 64; a++) begin
                fill_tmp = fill_word(soc_base + 32'(a * 4));
                for (int k = 0; k < 4; k++) begin
                    soc_bytes[a*4 + k] = fill_tmp[8*k +: 8];
                end
            end
            mtimecmp      = '1;
            mtime_hi      = '0;
            held_valid[0] = 1'b0;
            held_valid[1] = 1'b0;
            done_cnt[0]   = 0;
            done_cnt[1]   = 0;
        end else begin
            if (fetch_req_valid && fetch_req_ready) begin
                accept_request(fetch_req, exp_word);
                fetch_q.push_back(exp_word);
            end
            if (data_req_valid && data_req_ready) begin
                accept_request(data_req, exp_word);
                data_q.push_back(exp_word);
            end
            watch_response(0, fetch_rsp_valid, fetch_rsp_ready, fetch_rsp);
            watch_response(1, data_rsp_valid, data_rsp_ready, data_rsp);

            // fetch port stimulus
            if (fetch_req_valid && !fetch_req_ready) begin
                fetch_req_valid <= 1'b1;
            end else if (fetch_gap > 0) begin
                fetch_gap--;
                fetch_req_valid <= 1'b0;
            end else if (fetch_issued < num_trans) begin
                make_request(1'b0, new_req);
                fetch_req       <= new_req;
                fetch_req_valid <= 1'b1;
                fetch_issued++;
                fetch_gap = int'(rand_next() >> 29);
            end else begin
                fetch_req_valid <= 1'b0;
            end

            // data port stimulus
            if (data_req_valid && !data_req_ready) begin
                data_req_valid <= 1'b1;
            end else if (data_gap > 0) begin
                data_gap--;
                data_req_valid <= 1'b0;
            end else if (data_issued < num_trans) begin
                make_request(1'b1, new_req);
                data_req       <= new_req;
                data_req_valid <= 1'b1;
                data_issued++;
                data_gap = int'(rand_next() >> 29);
            end else begin
                data_req_valid <= 1'b0;
            end

            fetch_rsp_ready <= (rand_next() >> 30) != 32'd0;
            data_rsp_ready  <= (rand_next() >> 30) != 32'd0;
        end
    end

    initial begin
        @(negedge reset);
        while (done_cnt[0] < num_trans || done_cnt[1] < num_trans) begin
            @(posedge clock);
        end
        repeat (8) @(posedge clock);
        $display("errors: %0d value mismatches, %0d AXI protocol violations",
                 errors, axi_violations);
        if (errors == 0 && axi_violations == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // 60 cycles per transaction over both ports
    initial begin
        repeat (16 + 2 * num_trans * 60) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", 16 + 2 * num_trans * 60);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
verilog/mem_pkg.sv
verilog/mem_port_arbiter.sv
verilog/mem_addr_router.sv
verilog/clint_timer.sv
verilog/soc_axi_master.sv
verilog/mem_subsystem.sv
tb/tb_clock_gen.sv
tb/axi_mem_model.sv
tb/mem_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module mem_subsystem_tb \
    -f filelist.f \
    -o sim_mem_subsystem

output="$(./obj_dir/sim_mem_subsystem)"
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi
